// File: ooo_defs.svh
/*
 * shared sizing macros for the commit subsystem
 * word width, completion buffer depth and index width
 */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// data and address width
`define OOO_WORD_W 32

// completion buffer entries
`define OOO_CB_DEPTH 8

// index into the completion buffer, log2 of depth
`define OOO_CB_IDX_W 3

// architectural register index
`define OOO_REG_W 5

`endif

// File: ooo_types_pkg.sv
/*
 * types shared by write-back, completion buffer and testbench
 * functional unit results, buffer write port, predictor update, retire
 */
`include "ooo_defs.svh"

package ooo_types_pkg;

  typedef logic [`OOO_WORD_W-1:0]   word_t;
  typedef logic [`OOO_CB_IDX_W-1:0] cb_idx_t;
  typedef logic [`OOO_REG_W-1:0]    reg_idx_t;

  // exception cause carried to retire
  typedef enum logic [2:0] {
    CAUSE_NONE      = 3'd0,
    CAUSE_MAL_INSN  = 3'd1,  // jump/branch target not word aligned
    CAUSE_MAL_LOAD  = 3'd2,
    CAUSE_MAL_STORE = 3'd3,
    CAUSE_FAULT     = 3'd4   // unit raised its own exception
  } cause_t;

  // mul, div and load/store result
  typedef struct packed {
    logic     valid;      // one cycle strobe
    cb_idx_t  idx;
    reg_idx_t rd;
    logic     wen;
    word_t    data;
    word_t    pc;
    logic     exception;
  } fu_result_t;

  // alu result, adds branch and jump resolution
  typedef struct packed {
    logic     valid;
    cb_idx_t  idx;
    reg_idx_t rd;
    logic     wen;
    word_t    data;
    word_t    pc;
    logic     exception;
    logic     branch;
    logic     jump;
    logic     prediction; // predicted taken
    logic     taken;      // resolved taken
    word_t    br_target;  // resolved next pc of the branch
    word_t    j_target;
  } alu_result_t;

  // one completion buffer write port
  typedef struct packed {
    logic     valid;
    cb_idx_t  idx;
    reg_idx_t rd;
    logic     wen;
    word_t    data;      // result, redirect target or faulting pc
    logic     redirect;
    logic     exception;
    cause_t   cause;
  } cb_write_t;

  typedef struct packed {
    logic  valid;
    logic  prediction;
    logic  taken;
    word_t target;
  } pred_update_t;

  // entry leaving the head of the buffer
  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     wen;
    word_t    data;
    logic     redirect;
    logic     exception;
    cause_t   cause;
    word_t    epc;       // pc captured at allocation
  } retire_t;

endpackage

// File: ooo_writeback_stage.sv
/*
 * write-back classification, purely combinational
 * alu: mispredict detect, misaligned target check, predictor update
 * mul/div/ls: exception handling and load/store misalign causes
 * drives one completion buffer write per unit
 */
`timescale 1ns/1ps

module ooo_writeback_stage import ooo_types_pkg::*; (
  input  alu_result_t  alu_res,
  input  fu_result_t   mul_res,
  input  fu_result_t   div_res,
  input  fu_result_t   ls_res,
  input  logic         ls_load,      // 1 = load, 0 = store
  input  logic         ls_mal_addr,  // effective address misaligned
  output cb_write_t    cb_alu,
  output cb_write_t    cb_mul,
  output cb_write_t    cb_div,
  output cb_write_t    cb_ls,
  output pred_update_t pred_update
);

  logic mispredict;
  logic mal_jump;
  logic mal_branch;
  logic mal_insn;
  logic alu_exc;

  // common path for the non-alu units
  // mal only ever set for the load/store port
  function automatic cb_write_t fu_to_cb(input fu_result_t r, input logic mal,
                                         input logic load);
    cb_write_t w;
    logic      exc;
    exc         = r.exception | mal;
    w.valid     = r.valid;
    w.idx       = r.idx;
    w.rd        = r.rd;
    w.wen       = r.wen & ~exc;             // faulting op leaves rd alone
    w.data      = exc ? r.pc : r.data;       // pc kept for the handler
    w.redirect  = 1'b0;
    w.exception = exc;
    if (mal) begin
      w.cause = load ? CAUSE_MAL_LOAD : CAUSE_MAL_STORE;
    end else if (r.exception) begin
      w.cause = CAUSE_FAULT;
    end else begin
      w.cause = CAUSE_NONE;
    end
    return w;
  endfunction

  // alu branch/jump resolution
  assign mispredict = alu_res.branch & (alu_res.prediction ^ alu_res.taken);
  assign mal_jump   = alu_res.jump & (alu_res.j_target[1:0] != 2'b00);
  assign mal_branch = alu_res.branch & (alu_res.br_target[1:0] != 2'b00);
  assign mal_insn   = mal_jump | mal_branch;
  assign alu_exc    = alu_res.exception | mal_insn;

  always_comb begin
    cb_alu.valid = alu_res.valid;
    cb_alu.idx   = alu_res.idx;
    cb_alu.rd    = alu_res.rd;
    // branches and jumps never write rd
    cb_alu.wen   = alu_res.wen & ~(alu_exc | alu_res.branch | alu_res.jump);

    // priority: mispredict target, jump target, faulting pc, result
    if (mispredict) begin
      cb_alu.data = alu_res.br_target;
    end else if (alu_res.jump) begin
      cb_alu.data = alu_res.j_target;
    end else if (alu_exc) begin
      cb_alu.data = alu_res.pc;
    end else begin
      cb_alu.data = alu_res.data;
    end

    cb_alu.redirect  = (alu_res.jump | mispredict) & ~alu_exc; // exception wins
    cb_alu.exception = alu_exc;

    if (mal_insn) begin
      cb_alu.cause = CAUSE_MAL_INSN;
    end else if (alu_res.exception) begin
      cb_alu.cause = CAUSE_FAULT;
    end else begin
      cb_alu.cause = CAUSE_NONE;
    end
  end

  assign cb_mul = fu_to_cb(mul_res, 1'b0, 1'b0);
  assign cb_div = fu_to_cb(div_res, 1'b0, 1'b0);
  assign cb_ls  = fu_to_cb(ls_res, ls_mal_addr, ls_load);

  // predictor update in the same cycle as the branch strobe
  assign pred_update.valid      = alu_res.valid & alu_res.branch;
  assign pred_update.prediction = alu_res.prediction;
  assign pred_update.taken      = alu_res.taken;
  assign pred_update.target     = alu_res.br_target;

endmodule

// File: completion_buffer.sv
/*
 * reorder buffer: allocate in order, complete out of order,
 * retire one entry per cycle from the head
 * redirect or exception at retire flushes all younger entries
 */
`timescale 1ns/1ps
`include "ooo_defs.svh"

module completion_buffer import ooo_types_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      alloc,      // dispatch strobe
  input  word_t     alloc_pc,
  output cb_idx_t   alloc_idx,  // next free entry
  output logic      full,
  input  cb_write_t cb_alu,
  input  cb_write_t cb_mul,
  input  cb_write_t cb_div,
  input  cb_write_t cb_ls,
  output retire_t   retire
);

  localparam int N_PORTS = 4;
  localparam int CNT_W   = `OOO_CB_IDX_W + 1;

  // what a result writes into its entry
  typedef struct packed {
    reg_idx_t rd;
    logic     wen;
    word_t    data;
    logic     redirect;
    logic     exception;
    cause_t   cause;
  } cb_payload_t;

  cb_idx_t                  head;
  cb_idx_t                  tail;
  logic [CNT_W-1:0]         count;
  logic [`OOO_CB_DEPTH-1:0] valid_q;  // allocated, not yet retired
  logic [`OOO_CB_DEPTH-1:0] ready_q;  // result arrived

  word_t       pc_mem  [`OOO_CB_DEPTH];
  cb_payload_t payload [`OOO_CB_DEPTH];

  cb_write_t   wr [N_PORTS];
  cb_payload_t head_ent;
  logic        alloc_ok;
  logic        retire_go;
  logic        flush;

  assign wr[0] = cb_alu;
  assign wr[1] = cb_mul;
  assign wr[2] = cb_div;
  assign wr[3] = cb_ls;

  assign full      = (count == CNT_W'(`OOO_CB_DEPTH));
  assign alloc_idx = tail;
  assign alloc_ok  = alloc & ~full;  // alloc while full is dropped

  assign head_ent  = payload[head];
  assign retire_go = valid_q[head] & ready_q[head];
  assign flush     = retire_go & (head_ent.redirect | head_ent.exception);

  // pointers, count and entry state
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head    <= '0;
      tail    <= '0;
      count   <= '0;
      valid_q <= '0;
      ready_q <= '0;
    end else if (flush) begin
      // empty everything, same-cycle alloc is lost
      head    <= '0;
      tail    <= '0;
      count   <= '0;
      valid_q <= '0;
      ready_q <= '0;
    end else begin
      if (alloc_ok) begin
        valid_q[tail] <= 1'b1;
        ready_q[tail] <= 1'b0;
        tail          <= tail + 1'b1; // wraps at depth
      end
      for (int p = 0; p < N_PORTS; p++) begin
        if (wr[p].valid && valid_q[wr[p].idx]) begin
          ready_q[wr[p].idx] <= 1'b1;  // stale index of a flushed entry ignored
        end
      end
      if (retire_go) begin
        valid_q[head] <= 1'b0;
        ready_q[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      count <= count + CNT_W'(alloc_ok) - CNT_W'(retire_go);
    end
  end

  // entry storage
  always_ff @(posedge CLK) begin
    if (alloc_ok) begin
      pc_mem[tail] <= alloc_pc;
    end
    for (int p = 0; p < N_PORTS; p++) begin
      if (wr[p].valid && valid_q[wr[p].idx]) begin
        payload[wr[p].idx].rd        <= wr[p].rd;
        payload[wr[p].idx].wen       <= wr[p].wen;
        payload[wr[p].idx].data      <= wr[p].data;
        payload[wr[p].idx].redirect  <= wr[p].redirect;
        payload[wr[p].idx].exception <= wr[p].exception;
        payload[wr[p].idx].cause     <= wr[p].cause;
      end
    end
  end

  // registered retire port, one cycle behind the head check
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      retire <= '0;
    end else begin
      retire.valid     <= retire_go;
      retire.rd        <= head_ent.rd;
      retire.wen       <= head_ent.wen;
      retire.data      <= head_ent.data;   // target on redirect
      retire.redirect  <= head_ent.redirect;
      retire.exception <= head_ent.exception;
      retire.cause     <= head_ent.cause;
      retire.epc       <= pc_mem[head];    // allocated pc
    end
  end

endmodule

// File: ooo_commit_top.sv
/*
 * commit end of the out-of-order core
 * write-back classification feeding the completion buffer
 */
`timescale 1ns/1ps

module ooo_commit_top import ooo_types_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  // dispatch side
  input  logic         alloc,
  input  word_t        alloc_pc,
  output cb_idx_t      alloc_idx,
  output logic         full,        // dispatch must hold off
  // functional unit results
  input  alu_result_t  alu_res,
  input  fu_result_t   mul_res,
  input  fu_result_t   div_res,
  input  fu_result_t   ls_res,
  input  logic         ls_load,
  input  logic         ls_mal_addr,
  // to predictor and front end / regfile
  output pred_update_t pred_update,
  output retire_t      retire
);

  cb_write_t cb_alu;
  cb_write_t cb_mul;
  cb_write_t cb_div;
  cb_write_t cb_ls;

  ooo_writeback_stage i_writeback (
    .alu_res     (alu_res),
    .mul_res     (mul_res),
    .div_res     (div_res),
    .ls_res      (ls_res),
    .ls_load     (ls_load),
    .ls_mal_addr (ls_mal_addr),
    .cb_alu      (cb_alu),
    .cb_mul      (cb_mul),
    .cb_div      (cb_div),
    .cb_ls       (cb_ls),
    .pred_update (pred_update)
  );

  completion_buffer i_completion_buffer (
    .CLK       (CLK),
    .nRST      (nRST),
    .alloc     (alloc),
    .alloc_pc  (alloc_pc),
    .alloc_idx (alloc_idx),
    .full      (full),
    .cb_alu    (cb_alu),
    .cb_mul    (cb_mul),
    .cb_div    (cb_div),
    .cb_ls     (cb_ls),
    .retire    (retire)
  );

endmodule

// File: ooo_commit_assertions.sv
/*
 * bound concurrent checks on the commit top ports
 * dispatch against full, quiet cycle after a flush, predictor update source
 */
`timescale 1ns/1ps

module ooo_commit_assertions import ooo_types_pkg::*; (
  input logic         CLK,
  input logic         nRST,
  input logic         alloc,
  input logic         full,
  input alu_result_t  alu_res,
  input pred_update_t pred_update,
  input retire_t      retire
);

  // no back-pressure, dispatch has to honour full
  no_alloc_when_full: assert property (@(posedge CLK) disable iff (!nRST)
    full |-> !alloc)
    else $error("alloc while completion buffer is full");

  // flush empties the buffer, nothing left to retire next cycle
  quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
    retire.valid && (retire.redirect || retire.exception) |=> !retire.valid)
    else $error("retire strobe in the cycle after a flush");

  pred_only_on_branch: assert property (@(posedge CLK) disable iff (!nRST)
    pred_update.valid |-> alu_res.valid && alu_res.branch)
    else $error("predictor update without an alu branch result");

endmodule

bind ooo_commit_top ooo_commit_assertions i_commit_assertions (
  .CLK         (CLK),
  .nRST        (nRST),
  .alloc       (alloc),
  .full        (full),
  .alu_res     (alu_res),
  .pred_update (pred_update),
  .retire      (retire)
);

// File: tb_ooo_commit_top.sv
/*
 * testbench for the commit subsystem
 * lfsr data, compare tasks, directed tests, watchdog and summary
 */
`timescale 1ns/1ps
`include "ooo_defs.svh"

module tb_ooo_commit_top import ooo_types_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 150;  // generous budget per test
  localparam int RETIRE_WAIT = 40;   // idle cycles before a drain gives up

  logic         CLK;
  logic         nRST;
  logic         alloc;
  word_t        alloc_pc;
  cb_idx_t      alloc_idx;
  logic         full;
  alu_result_t  alu_res;
  fu_result_t   mul_res;
  fu_result_t   div_res;
  fu_result_t   ls_res;
  logic         ls_load;
  logic         ls_mal_addr;
  pred_update_t pred_update;
  retire_t      retire;

  logic [15:0] lfsr_q;
  int          errors;
  int          checks;
  cb_idx_t     next_idx;   // index the buffer should hand out next
  retire_t     exp_q [$];  // expected retires, allocation order

  ooo_commit_top i_ooo_commit_top (
    .CLK         (CLK),
    .nRST        (nRST),
    .alloc       (alloc),
    .alloc_pc    (alloc_pc),
    .alloc_idx   (alloc_idx),
    .full        (full),
    .alu_res     (alu_res),
    .mul_res     (mul_res),
    .div_res     (div_res),
    .ls_res      (ls_res),
    .ls_load     (ls_load),
    .ls_mal_addr (ls_mal_addr),
    .pred_update (pred_update),
    .retire      (retire)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // watchdog, reset plus a budget per test
  initial begin
    #(CLK_PERIOD * (8 + N_TESTS * TEST_CYCLES));
    $display("watchdog expired, tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  // fibonacci lfsr x^16+x^14+x^13+x^11, one step per bit taken
  function automatic word_t rnd(input int nbits);
    word_t w;
    logic  fb;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      w      = {w[`OOO_WORD_W-2:0], fb};
    end
    return w;
  endfunction

  task automatic check_retire(input retire_t got, input retire_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED retire: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_pred(input pred_update_t got, input pred_update_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED pred_update: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_idx(input cb_idx_t got, input cb_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED alloc_idx: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // random register-write result from the unit for the entry at pc
  function automatic fu_result_t rand_res(input word_t pc);
    fu_result_t r;
    r       = '0;
    r.valid = 1'b1;
    r.rd    = reg_idx_t'(rnd(5));
    r.wen   = 1'b1;
    r.data  = rnd(32);
    r.pc    = pc;
    return r;
  endfunction

  // same fields on the alu port, no branch or jump
  function automatic alu_result_t alu_from(input fu_result_t f);
    return alu_result_t'{f.valid, f.idx, f.rd, f.wen, f.data, f.pc, f.exception,
                         1'b0, 1'b0, 1'b0, 1'b0, '0, '0};
  endfunction

  // one-cycle alloc strobe, index checked against the in-order model
  task automatic alloc_entry(input retire_t exp, output cb_idx_t idx);
    @(posedge CLK);
    alloc    <= 1'b1;
    alloc_pc <= exp.epc;
    @(negedge CLK);
    check_flag("full", full, 1'b0);
    check_idx(alloc_idx, next_idx);
    idx = next_idx;
    next_idx++;           // wraps with the buffer
    exp_q.push_back(exp);
    @(posedge CLK);
    alloc <= 1'b0;
  endtask

  // plain entry, retires as a register write of its data
  task automatic alloc_plain(input word_t pc, output fu_result_t r);
    cb_idx_t idx;
    r = rand_res(pc);
    alloc_entry(retire_t'{1'b1, r.rd, 1'b1, r.data, 1'b0, 1'b0, CAUSE_NONE, pc}, idx);
    r.idx = idx;
  endtask

  // one-cycle result strobes, predictor update checked in the same cycle
  task automatic send_results(input alu_result_t a, input fu_result_t m, input fu_result_t d,
                              input fu_result_t l, input logic load, input logic mal);
    @(posedge CLK);
    alu_res     <= a;
    mul_res     <= m;
    div_res     <= d;
    ls_res      <= l;
    ls_load     <= load;
    ls_mal_addr <= mal;
    @(negedge CLK);
    if (a.valid && a.branch) begin
      check_pred(pred_update, pred_update_t'{1'b1, a.prediction, a.taken, a.br_target});
    end else begin
      check_flag("pred_update.valid", pred_update.valid, 1'b0);
    end
    @(posedge CLK);
    alu_res     <= '0;
    mul_res     <= '0;
    div_res     <= '0;
    ls_res      <= '0;
    ls_load     <= 1'b0;
    ls_mal_addr <= 1'b0;
  endtask

  // wait for every expected retire, in order
  task automatic drain();
    retire_t exp;
    int      idle;
    idle = 0;
    while (exp_q.size() > 0) begin
      @(negedge CLK);
      if (retire.valid) begin
        exp  = exp_q.pop_front();
        idle = 0;
        check_retire(retire, exp);
        if (exp.redirect || exp.exception) begin
          exp_q.delete();   // younger entries flushed
          next_idx = '0;
        end
      end else begin
        idle++;
        if (idle > RETIRE_WAIT) begin
          errors++;
          $display("no retire within %0d cycles, %0d entries still expected",
                   RETIRE_WAIT, exp_q.size());
          exp_q.delete();
        end
      end
    end
  endtask

  task automatic quiet(input int n);
    repeat (n) begin
      @(negedge CLK);
      check_flag("retire.valid", retire.valid, 1'b0);
    end
  endtask

  task automatic end_test(input string name, input int e0);
    $display("%-16s %s, %0d errors", name, (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  task automatic test_inorder();
    fu_result_t r [4];
    int         e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      alloc_plain(32'h1000 + 32'(4 * i), r[i]);
    end
    send_results(alu_from(r[0]), r[1], r[2], r[3], 1'b1, 1'b0);  // aligned load on ls
    drain();
    end_test("in-order mix", e0);
  endtask

  task automatic test_reverse();
    fu_result_t r [4];
    int         e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      alloc_plain(32'h2000 + 32'(4 * i), r[i]);
    end
    for (int i = 3; i >= 0; i--) begin
      send_results('0, r[i], '0, '0, 1'b0, 1'b0);
      if (i > 0) begin
        quiet(2);  // head still waiting
      end
    end
    drain();
    end_test("reverse results", e0);
  endtask

  task automatic test_mispredict();
    alu_result_t a;
    fu_result_t  m;
    fu_result_t  d;
    cb_idx_t     idx;
    int          e0;
    e0           = errors;
    a            = alu_from(rand_res(32'h3000));
    a.branch     = 1'b1;
    a.prediction = 1'b0;
    a.taken      = 1'b1;
    a.br_target  = rnd(32) & 32'hFFFF_FFFC;  // word aligned
    alloc_entry(retire_t'{1'b1, a.rd, 1'b0, a.br_target, 1'b1, 1'b0, CAUSE_NONE, a.pc}, idx);
    a.idx = idx;
    alloc_plain(32'h3004, m);
    alloc_plain(32'h3008, d);
    send_results('0, m, d, '0, 1'b0, 1'b0);  // younger finish first
    send_results(a, '0, '0, '0, 1'b0, 1'b0);
    drain();
    quiet(4);  // flushed entries never show up
    end_test("mispredict", e0);
  endtask

  task automatic test_predicted();
    alu_result_t a;
    fu_result_t  m;
    fu_result_t  l;
    cb_idx_t     idx;
    int          e0;
    e0           = errors;
    a            = alu_from(rand_res(32'h4000));
    a.branch     = 1'b1;
    a.prediction = 1'b1;
    a.taken      = 1'b1;
    a.br_target  = rnd(32) & 32'hFFFF_FFFC;
    // correct guess, no redirect and no rd write
    alloc_entry(retire_t'{1'b1, a.rd, 1'b0, a.data, 1'b0, 1'b0, CAUSE_NONE, a.pc}, idx);
    a.idx = idx;
    alloc_plain(32'h4004, m);
    alloc_plain(32'h4008, l);
    send_results(a, m, '0, l, 1'b0, 1'b0);  // aligned store on ls
    drain();
    end_test("predicted branch", e0);
  endtask

  task automatic test_wrap_full();
    fu_result_t r [`OOO_CB_DEPTH];
    int         e0;
    e0 = errors;
    for (int i = 0; i < `OOO_CB_DEPTH; i++) begin
      alloc_plain(32'h5000 + 32'(4 * i), r[i]);  // indices run past the top
    end
    @(negedge CLK);
    check_flag("full", full, 1'b1);
    for (int i = `OOO_CB_DEPTH - 1; i >= 0; i--) begin
      send_results('0, r[i], '0, '0, 1'b0, 1'b0);
    end
    drain();
    check_flag("full", full, 1'b0);
    end_test("wrap and full", e0);
  endtask

  task automatic test_exceptions();
    alu_result_t a;
    fu_result_t  l;
    fu_result_t  m;
    cb_idx_t     idx;
    int          e0;
    e0 = errors;
    l  = rand_res(32'h6000);  // faulting pc goes out in the data word
    alloc_entry(retire_t'{1'b1, l.rd, 1'b0, l.pc, 1'b0, 1'b1, CAUSE_MAL_LOAD, l.pc}, idx);
    l.idx = idx;
    alloc_plain(32'h6004, m);
    send_results('0, m, '0, '0, 1'b0, 1'b0);
    send_results('0, '0, '0, l, 1'b1, 1'b1);
    drain();
    quiet(3);
    a          = alu_from(rand_res(32'h6100));
    a.jump     = 1'b1;
    a.j_target = rnd(32) | 32'h2;  // bit 1 set, never aligned
    // exception outranks the jump redirect
    alloc_entry(retire_t'{1'b1, a.rd, 1'b0, a.j_target, 1'b0, 1'b1, CAUSE_MAL_INSN, a.pc}, idx);
    a.idx = idx;
    alloc_plain(32'h6104, m);
    send_results('0, '0, m, '0, 1'b0, 1'b0);  // younger on the div port
    send_results(a, '0, '0, '0, 1'b0, 1'b0);
    drain();
    quiet(3);
    end_test("exceptions", e0);
  endtask

  initial begin
    lfsr_q      = 16'd8763;
    errors      = 0;
    checks      = 0;
    next_idx    = '0;
    CLK         = 1'b0;
    nRST        = 1'b0;
    alloc       = 1'b0;
    alloc_pc    = '0;
    alu_res     = '0;
    mul_res     = '0;
    div_res     = '0;
    ls_res      = '0;
    ls_load     = 1'b0;
    ls_mal_addr = 1'b0;
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_flag("full", full, 1'b0);  // empty after reset
    check_flag("retire.valid", retire.valid, 1'b0);
    check_flag("pred_update.valid", pred_update.valid, 1'b0);
    test_inorder();
    test_reverse();
    test_mispredict();
    test_predicted();
    test_wrap_full();   // starts mid-buffer, so indices wrap
    test_exceptions();
    $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: ooo_commit_top.f
+incdir+.
ooo_types_pkg.sv
ooo_writeback_stage.sv
completion_buffer.sv
ooo_commit_top.sv
ooo_commit_assertions.sv
tb_ooo_commit_top.sv

// File: run_sim.sh
#!/bin/sh
# build the commit testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_commit_top \
  -f ooo_commit_top.f -o sim_tb &&
  ./obj_dir/sim_tb > sim.log 2>&1 || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
